/* post_decode_pkg.sv */
package post_decode_pkg;

    localparam int SLOTS      = 2;
    localparam int INST_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int ROB_IDX_W  = 6;
    localparam int PREG_W     = 7;
    localparam int CSR_ADDR_W = 12;
    localparam int FU_W       = 3;
    localparam int UOP_CTRL_W = 16;

    localparam logic [FU_W-1:0] FU_INT    = 3'd0;
    localparam logic [FU_W-1:0] FU_MULDIV = 3'd1;
    localparam logic [FU_W-1:0] FU_BRANCH = 3'd2;
    localparam logic [FU_W-1:0] FU_LSU    = 3'd3;
    localparam logic [FU_W-1:0] FU_SYSTEM = 3'd4;
    localparam logic [FU_W-1:0] FU_NONE   = 3'd7; // Illegal or empty slot

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SLL = 3'd1;
    localparam logic [2:0] ALU_CMP = 3'd2; // SLT and SLTU
    localparam logic [2:0] ALU_XOR = 3'd3;
    localparam logic [2:0] ALU_SRL = 3'd4;
    localparam logic [2:0] ALU_SRA = 3'd5;
    localparam logic [2:0] ALU_OR  = 3'd6;
    localparam logic [2:0] ALU_AND = 3'd7;

    localparam logic [3:0] BR_NONE = 4'd0;
    localparam logic [3:0] BR_BEQ  = 4'd1;
    localparam logic [3:0] BR_BNE  = 4'd2;
    localparam logic [3:0] BR_BLT  = 4'd3;
    localparam logic [3:0] BR_BGE  = 4'd4;
    localparam logic [3:0] BR_BLTU = 4'd5;
    localparam logic [3:0] BR_BGEU = 4'd6;
    localparam logic [3:0] BR_JAL  = 4'd7;
    localparam logic [3:0] BR_JALR = 4'd8;

    localparam logic [1:0] MEM_BYTE = 2'd0;
    localparam logic [1:0] MEM_HALF = 2'd1;
    localparam logic [1:0] MEM_WORD = 2'd2;

    localparam logic [1:0] CSR_NONE = 2'd0;
    localparam logic [1:0] CSR_RW   = 2'd1;
    localparam logic [1:0] CSR_RS   = 2'd2;
    localparam logic [1:0] CSR_RC   = 2'd3;

    // fu_sel tells which view holds
    typedef union packed {
        struct packed {
            logic [UOP_CTRL_W-6:0] pad;
            logic [2:0]            alu_op;
            logic                  is_sub;
            logic                  cmp_signed;
        } int_v;
        struct packed {
            logic [UOP_CTRL_W-7:0] pad;
            logic                  is_div;
            logic                  mul_high;
            logic                  mul_signed_rs1;
            logic                  mul_signed_rs2;
            logic                  div_signed;
            logic                  is_rem;
        } md_v;
        struct packed {
            logic [UOP_CTRL_W-5:0] pad;
            logic [3:0]            br_op;
        } br_v;
        struct packed {
            logic [UOP_CTRL_W-5:0] pad;
            logic                  is_load;
            logic [1:0]            mem_size;
            logic                  mem_unsigned;
        } mem_v;
        struct packed {
            logic [UOP_CTRL_W-CSR_ADDR_W-3:0] pad;
            logic [1:0]                       csr_op;
            logic [CSR_ADDR_W-1:0]            csr_addr;
        } csr_v;
    } uop_ctrl_u;

endpackage

/* uop_bus_if.sv */
`timescale 1ns/1ps

interface uop_bus_if;

    logic valid;
    logic ready;
    logic [post_decode_pkg::SLOTS-1:0] slot_valid;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::FU_W-1:0] fu_sel;
    post_decode_pkg::uop_ctrl_u [post_decode_pkg::SLOTS-1:0] ctrl;
    logic [post_decode_pkg::SLOTS-1:0] illegal;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::ADDR_W-1:0] pc;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::ROB_IDX_W-1:0] rob_idx;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::PREG_W-1:0] rd_preg;

    modport producer (
        output valid, slot_valid, fu_sel, ctrl, illegal, pc, rob_idx, rd_preg,
        input  ready
    );

    modport consumer (
        input  valid, slot_valid, fu_sel, ctrl, illegal, pc, rob_idx, rd_preg,
        output ready
    );

endinterface

/* uop_decoder.sv */
`timescale 1ns/1ps

module uop_decoder (
    input  logic [post_decode_pkg::INST_W-1:0] inst,
    output logic [post_decode_pkg::FU_W-1:0]   fu_sel,
    output post_decode_pkg::uop_ctrl_u         ctrl,
    output logic                               illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        fu_sel  = post_decode_pkg::FU_NONE;
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            post_decode_pkg::OPC_OP, post_decode_pkg::OPC_OP_IMM: begin
                if (opcode == post_decode_pkg::OPC_OP && funct7 == 7'b0000001) begin
                    fu_sel = post_decode_pkg::FU_MULDIV;
                    ctrl.md_v.is_div         = funct3[2];
                    ctrl.md_v.mul_high       = !funct3[2] && funct3[1:0] != 2'b00;
                    ctrl.md_v.mul_signed_rs1 = !funct3[2] && funct3[1:0] != 2'b11;
                    ctrl.md_v.mul_signed_rs2 = !funct3[2] && !funct3[1]; // MUL, MULH
                    ctrl.md_v.div_signed     = funct3[2] && !funct3[0];  // DIV, REM
                    ctrl.md_v.is_rem         = funct3[2] && funct3[1];
                end else begin
                    fu_sel = post_decode_pkg::FU_INT;
                    case (funct3)
                        3'b000: begin
                            ctrl.int_v.alu_op = post_decode_pkg::ALU_ADD;
                            ctrl.int_v.is_sub = opcode == post_decode_pkg::OPC_OP &&
                                                funct7 == 7'b0100000;
                        end
                        3'b001: ctrl.int_v.alu_op = post_decode_pkg::ALU_SLL;
                        3'b010, 3'b011: begin
                            ctrl.int_v.alu_op     = post_decode_pkg::ALU_CMP;
                            ctrl.int_v.cmp_signed = !funct3[0];
                        end
                        3'b100: ctrl.int_v.alu_op = post_decode_pkg::ALU_XOR;
                        3'b101: begin
                            ctrl.int_v.alu_op = (funct7 == 7'b0100000) ?
                                                post_decode_pkg::ALU_SRA :
                                                post_decode_pkg::ALU_SRL;
                        end
                        3'b110: ctrl.int_v.alu_op = post_decode_pkg::ALU_OR;
                        default: ctrl.int_v.alu_op = post_decode_pkg::ALU_AND;
                    endcase
                end
            end
            post_decode_pkg::OPC_LUI, post_decode_pkg::OPC_AUIPC: begin
                fu_sel = post_decode_pkg::FU_INT;
                ctrl.int_v.alu_op = post_decode_pkg::ALU_ADD; // Imm or PC plus imm
            end
            post_decode_pkg::OPC_JAL: begin
                fu_sel = post_decode_pkg::FU_BRANCH;
                ctrl.br_v.br_op = post_decode_pkg::BR_JAL;
            end
            post_decode_pkg::OPC_JALR: begin
                fu_sel = post_decode_pkg::FU_BRANCH;
                ctrl.br_v.br_op = post_decode_pkg::BR_JALR;
                illegal = funct3 != 3'b000;
            end
            post_decode_pkg::OPC_BRANCH: begin
                fu_sel = post_decode_pkg::FU_BRANCH;
                case (funct3)
                    3'b000: ctrl.br_v.br_op = post_decode_pkg::BR_BEQ;
                    3'b001: ctrl.br_v.br_op = post_decode_pkg::BR_BNE;
                    3'b100: ctrl.br_v.br_op = post_decode_pkg::BR_BLT;
                    3'b101: ctrl.br_v.br_op = post_decode_pkg::BR_BGE;
                    3'b110: ctrl.br_v.br_op = post_decode_pkg::BR_BLTU;
                    3'b111: ctrl.br_v.br_op = post_decode_pkg::BR_BGEU;
                    default: begin
                        ctrl.br_v.br_op = post_decode_pkg::BR_NONE;
                        illegal = 1'b1;
                    end
                endcase
            end
            post_decode_pkg::OPC_LOAD, post_decode_pkg::OPC_STORE: begin
                fu_sel = post_decode_pkg::FU_LSU;
                ctrl.mem_v.is_load      = opcode == post_decode_pkg::OPC_LOAD;
                ctrl.mem_v.mem_unsigned = funct3[2]; // LBU, LHU
                case (funct3[1:0])
                    2'b00: ctrl.mem_v.mem_size = post_decode_pkg::MEM_BYTE;
                    2'b01: ctrl.mem_v.mem_size = post_decode_pkg::MEM_HALF;
                    2'b10: ctrl.mem_v.mem_size = post_decode_pkg::MEM_WORD;
                    default: illegal = 1'b1;
                endcase
                // No unsigned stores and no unsigned word loads
                if (funct3[2] && (opcode == post_decode_pkg::OPC_STORE || funct3[1]))
                    illegal = 1'b1;
            end
            post_decode_pkg::OPC_MISC_MEM: begin
                fu_sel = post_decode_pkg::FU_SYSTEM; // FENCE, FENCE.I
                illegal = funct3[2:1] != 2'b00;
            end
            post_decode_pkg::OPC_SYSTEM: begin
                fu_sel = post_decode_pkg::FU_SYSTEM;
                ctrl.csr_v.csr_addr = inst[31:20];
                case (funct3[1:0])
                    2'b01: ctrl.csr_v.csr_op = post_decode_pkg::CSR_RW;
                    2'b10: ctrl.csr_v.csr_op = post_decode_pkg::CSR_RS;
                    2'b11: ctrl.csr_v.csr_op = post_decode_pkg::CSR_RC;
                    default: begin
                        ctrl.csr_v.csr_op = post_decode_pkg::CSR_NONE; // ECALL, MRET, WFI
                        illegal = funct3[2];
                    end
                endcase
            end
            default: illegal = 1'b1; // FP and unknown opcodes
        endcase
        if (illegal) begin
            fu_sel = post_decode_pkg::FU_NONE;
            ctrl   = '0;
        end
    end

endmodule

/* bundle_decode.sv */
`timescale 1ns/1ps

module bundle_decode (
    input  logic                                  in_valid,
    input  logic [post_decode_pkg::SLOTS-1:0]     in_slot_valid,
    input  logic [post_decode_pkg::INST_W-1:0]    in_inst_0,
    input  logic [post_decode_pkg::INST_W-1:0]    in_inst_1,
    input  logic [post_decode_pkg::ADDR_W-1:0]    in_pc_0,
    input  logic [post_decode_pkg::ADDR_W-1:0]    in_pc_1,
    input  logic [post_decode_pkg::ROB_IDX_W-1:0] in_rob_idx_0,
    input  logic [post_decode_pkg::ROB_IDX_W-1:0] in_rob_idx_1,
    input  logic [post_decode_pkg::PREG_W-1:0]    in_rd_preg_0,
    input  logic [post_decode_pkg::PREG_W-1:0]    in_rd_preg_1,
    uop_bus_if.producer                           bus
);

    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::INST_W-1:0]    inst;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::ADDR_W-1:0]    pc;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::ROB_IDX_W-1:0] rob_idx;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::PREG_W-1:0]    rd_preg;
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::FU_W-1:0]      dec_fu;
    post_decode_pkg::uop_ctrl_u [post_decode_pkg::SLOTS-1:0]           dec_ctrl;
    logic [post_decode_pkg::SLOTS-1:0]                                 dec_illegal;

    assign inst    = {in_inst_1, in_inst_0};
    assign pc      = {in_pc_1, in_pc_0};
    assign rob_idx = {in_rob_idx_1, in_rob_idx_0};
    assign rd_preg = {in_rd_preg_1, in_rd_preg_0};

    assign bus.valid      = in_valid;
    assign bus.slot_valid = in_slot_valid;

    for (genvar i = 0; i < post_decode_pkg::SLOTS; i++) begin : g_slot
        uop_decoder u_uop_decoder (
            .inst    (inst[i]),
            .fu_sel  (dec_fu[i]),
            .ctrl    (dec_ctrl[i]),
            .illegal (dec_illegal[i])
        );

        // Empty slot goes out cleared
        assign bus.fu_sel[i]  = in_slot_valid[i] ? dec_fu[i] : post_decode_pkg::FU_NONE;
        assign bus.ctrl[i]    = in_slot_valid[i] ? dec_ctrl[i] : '0;
        assign bus.illegal[i] = in_slot_valid[i] && dec_illegal[i];
        assign bus.pc[i]      = in_slot_valid[i] ? pc[i] : '0;
        assign bus.rob_idx[i] = in_slot_valid[i] ? rob_idx[i] : '0;
        assign bus.rd_preg[i] = in_slot_valid[i] ? rd_preg[i] : '0;
    end

endmodule

/* bundle_buffer.sv */
`timescale 1ns/1ps

module bundle_buffer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    uop_bus_if.consumer                           bus,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [post_decode_pkg::SLOTS-1:0]     out_slot_valid,
    output logic [post_decode_pkg::FU_W-1:0]      out_fu_sel_0,
    output logic [post_decode_pkg::FU_W-1:0]      out_fu_sel_1,
    output post_decode_pkg::uop_ctrl_u            out_ctrl_0,
    output post_decode_pkg::uop_ctrl_u            out_ctrl_1,
    output logic                                  out_illegal_0,
    output logic                                  out_illegal_1,
    output logic [post_decode_pkg::ADDR_W-1:0]    out_pc_0,
    output logic [post_decode_pkg::ADDR_W-1:0]    out_pc_1,
    output logic [post_decode_pkg::ROB_IDX_W-1:0] out_rob_idx_0,
    output logic [post_decode_pkg::ROB_IDX_W-1:0] out_rob_idx_1,
    output logic [post_decode_pkg::PREG_W-1:0]    out_rd_preg_0,
    output logic [post_decode_pkg::PREG_W-1:0]    out_rd_preg_1
);

    logic [post_decode_pkg::SLOTS-1:0]                                 slot_valid_q [2];
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::FU_W-1:0]      fu_sel_q [2];
    post_decode_pkg::uop_ctrl_u [post_decode_pkg::SLOTS-1:0]           ctrl_q [2];
    logic [post_decode_pkg::SLOTS-1:0]                                 illegal_q [2];
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::ADDR_W-1:0]    pc_q [2];
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::ROB_IDX_W-1:0] rob_idx_q [2];
    logic [post_decode_pkg::SLOTS-1:0][post_decode_pkg::PREG_W-1:0]    rd_preg_q [2];

    logic       head;
    logic       tail;
    logic [1:0] count;
    logic [1:0] count_nxt;
    logic       push;
    logic       pop;

    assign push = bus.valid && bus.ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        count_nxt = count;
        if (push && !pop)
            count_nxt = count + 2'd1;
        else if (pop && !push)
            count_nxt = count - 2'd1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head      <= 1'b0;
            tail      <= 1'b0;
            count     <= 2'd0;
            bus.ready <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            if (push)
                tail <= !tail;
            if (pop)
                head <= !head;
            count     <= count_nxt;
            bus.ready <= count_nxt != 2'd2; // Room for one more
            out_valid <= count_nxt != 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slot_valid_q[tail] <= bus.slot_valid;
            fu_sel_q[tail]     <= bus.fu_sel;
            ctrl_q[tail]       <= bus.ctrl;
            illegal_q[tail]    <= bus.illegal;
            pc_q[tail]         <= bus.pc;
            rob_idx_q[tail]    <= bus.rob_idx;
            rd_preg_q[tail]    <= bus.rd_preg;
        end
    end

    // Head entry held until popped
    assign out_slot_valid = slot_valid_q[head];
    assign out_fu_sel_0   = fu_sel_q[head][0];
    assign out_fu_sel_1   = fu_sel_q[head][1];
    assign out_ctrl_0     = ctrl_q[head][0];
    assign out_ctrl_1     = ctrl_q[head][1];
    assign out_illegal_0  = illegal_q[head][0];
    assign out_illegal_1  = illegal_q[head][1];
    assign out_pc_0       = pc_q[head][0];
    assign out_pc_1       = pc_q[head][1];
    assign out_rob_idx_0  = rob_idx_q[head][0];
    assign out_rob_idx_1  = rob_idx_q[head][1];
    assign out_rd_preg_0  = rd_preg_q[head][0];
    assign out_rd_preg_1  = rd_preg_q[head][1];

endmodule

/* post_decode.sv */
`timescale 1ns/1ps

module post_decode (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [post_decode_pkg::SLOTS-1:0]     in_slot_valid,
    input  logic [post_decode_pkg::INST_W-1:0]    in_inst_0,
    input  logic [post_decode_pkg::INST_W-1:0]    in_inst_1,
    input  logic [post_decode_pkg::ADDR_W-1:0]    in_pc_0,
    input  logic [post_decode_pkg::ADDR_W-1:0]    in_pc_1,
    input  logic [post_decode_pkg::ROB_IDX_W-1:0] in_rob_idx_0,
    input  logic [post_decode_pkg::ROB_IDX_W-1:0] in_rob_idx_1,
    input  logic [post_decode_pkg::PREG_W-1:0]    in_rd_preg_0,
    input  logic [post_decode_pkg::PREG_W-1:0]    in_rd_preg_1,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [post_decode_pkg::SLOTS-1:0]     out_slot_valid,
    output logic [post_decode_pkg::FU_W-1:0]      out_fu_sel_0,
    output logic [post_decode_pkg::FU_W-1:0]      out_fu_sel_1,
    output post_decode_pkg::uop_ctrl_u            out_ctrl_0,
    output post_decode_pkg::uop_ctrl_u            out_ctrl_1,
    output logic                                  out_illegal_0,
    output logic                                  out_illegal_1,
    output logic [post_decode_pkg::ADDR_W-1:0]    out_pc_0,
    output logic [post_decode_pkg::ADDR_W-1:0]    out_pc_1,
    output logic [post_decode_pkg::ROB_IDX_W-1:0] out_rob_idx_0,
    output logic [post_decode_pkg::ROB_IDX_W-1:0] out_rob_idx_1,
    output logic [post_decode_pkg::PREG_W-1:0]    out_rd_preg_0,
    output logic [post_decode_pkg::PREG_W-1:0]    out_rd_preg_1
);

    uop_bus_if bus ();

    assign in_ready = bus.ready;

    bundle_decode u_bundle_decode (
        .in_valid      (in_valid),
        .in_slot_valid (in_slot_valid),
        .in_inst_0     (in_inst_0),
        .in_inst_1     (in_inst_1),
        .in_pc_0       (in_pc_0),
        .in_pc_1       (in_pc_1),
        .in_rob_idx_0  (in_rob_idx_0),
        .in_rob_idx_1  (in_rob_idx_1),
        .in_rd_preg_0  (in_rd_preg_0),
        .in_rd_preg_1  (in_rd_preg_1),
        .bus           (bus)
    );

    bundle_buffer u_bundle_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus            (bus),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_slot_valid (out_slot_valid),
        .out_fu_sel_0   (out_fu_sel_0),
        .out_fu_sel_1   (out_fu_sel_1),
        .out_ctrl_0     (out_ctrl_0),
        .out_ctrl_1     (out_ctrl_1),
        .out_illegal_0  (out_illegal_0),
        .out_illegal_1  (out_illegal_1),
        .out_pc_0       (out_pc_0),
        .out_pc_1       (out_pc_1),
        .out_rob_idx_0  (out_rob_idx_0),
        .out_rob_idx_1  (out_rob_idx_1),
        .out_rd_preg_0  (out_rd_preg_0),
        .out_rd_preg_1  (out_rd_preg_1)
    );

endmodule

/* tb_vectors.svh */
task automatic load_table();
    // Each row holds name, instruction word, fu_sel, ctrl word and illegal
    add_row("add",        32'h003100B3, post_decode_pkg::FU_INT,    16'h0000, 1'b0);
    add_row("sub",        32'h403100B3, post_decode_pkg::FU_INT,    16'h0002, 1'b0);
    add_row("sll",        32'h003110B3, post_decode_pkg::FU_INT,    16'h0004, 1'b0);
    add_row("slt",        32'h003120B3, post_decode_pkg::FU_INT,    16'h0009, 1'b0);
    add_row("sltu",       32'h003130B3, post_decode_pkg::FU_INT,    16'h0008, 1'b0);
    add_row("srl",        32'h003150B3, post_decode_pkg::FU_INT,    16'h0010, 1'b0);
    add_row("sra",        32'h403150B3, post_decode_pkg::FU_INT,    16'h0014, 1'b0);
    add_row("and",        32'h003170B3, post_decode_pkg::FU_INT,    16'h001C, 1'b0);
    add_row("addi_bit30", 32'h40010093, post_decode_pkg::FU_INT,    16'h0000, 1'b0); // No sub
    add_row("srai",       32'h40315093, post_decode_pkg::FU_INT,    16'h0014, 1'b0);
    add_row("lui",        32'h123450B7, post_decode_pkg::FU_INT,    16'h0000, 1'b0);
    add_row("auipc",      32'h00001097, post_decode_pkg::FU_INT,    16'h0000, 1'b0);
    add_row("mul",        32'h023100B3, post_decode_pkg::FU_MULDIV, 16'h000C, 1'b0);
    add_row("mulh",       32'h023110B3, post_decode_pkg::FU_MULDIV, 16'h001C, 1'b0);
    add_row("mulhsu",     32'h023120B3, post_decode_pkg::FU_MULDIV, 16'h0018, 1'b0);
    add_row("mulhu",      32'h023130B3, post_decode_pkg::FU_MULDIV, 16'h0010, 1'b0);
    add_row("div",        32'h023140B3, post_decode_pkg::FU_MULDIV, 16'h0022, 1'b0);
    add_row("divu",       32'h023150B3, post_decode_pkg::FU_MULDIV, 16'h0020, 1'b0);
    add_row("rem",        32'h023160B3, post_decode_pkg::FU_MULDIV, 16'h0023, 1'b0);
    add_row("remu",       32'h023170B3, post_decode_pkg::FU_MULDIV, 16'h0021, 1'b0);
    add_row("beq",        32'h00310463, post_decode_pkg::FU_BRANCH, 16'h0001, 1'b0);
    add_row("bne",        32'h00311463, post_decode_pkg::FU_BRANCH, 16'h0002, 1'b0);
    add_row("blt",        32'h00314463, post_decode_pkg::FU_BRANCH, 16'h0003, 1'b0);
    add_row("bge",        32'h00315463, post_decode_pkg::FU_BRANCH, 16'h0004, 1'b0);
    add_row("bltu",       32'h00316463, post_decode_pkg::FU_BRANCH, 16'h0005, 1'b0);
    add_row("bgeu",       32'h00317463, post_decode_pkg::FU_BRANCH, 16'h0006, 1'b0);
    add_row("jal",        32'h000000EF, post_decode_pkg::FU_BRANCH, 16'h0007, 1'b0);
    add_row("jalr",       32'h000100E7, post_decode_pkg::FU_BRANCH, 16'h0008, 1'b0);
    add_row("lb",         32'h00010083, post_decode_pkg::FU_LSU,    16'h0008, 1'b0);
    add_row("lh",         32'h00011083, post_decode_pkg::FU_LSU,    16'h000A, 1'b0);
    add_row("lw",         32'h00012083, post_decode_pkg::FU_LSU,    16'h000C, 1'b0);
    add_row("lbu",        32'h00014083, post_decode_pkg::FU_LSU,    16'h0009, 1'b0);
    add_row("lhu",        32'h00015083, post_decode_pkg::FU_LSU,    16'h000B, 1'b0);
    add_row("sb",         32'h00310023, post_decode_pkg::FU_LSU,    16'h0000, 1'b0);
    add_row("sw",         32'h00312023, post_decode_pkg::FU_LSU,    16'h0004, 1'b0);
    add_row("csrrw",      32'h300110F3, post_decode_pkg::FU_SYSTEM, 16'h1300, 1'b0);
    add_row("csrrs",      32'hC00020F3, post_decode_pkg::FU_SYSTEM, 16'h2C00, 1'b0);
    add_row("csrrc",      32'h341130F3, post_decode_pkg::FU_SYSTEM, 16'h3341, 1'b0);
    add_row("csrrwi",     32'h3052D0F3, post_decode_pkg::FU_SYSTEM, 16'h1305, 1'b0);
    add_row("csrrci",     32'hFFF070F3, post_decode_pkg::FU_SYSTEM, 16'h3FFF, 1'b0);
    add_row("ecall",      32'h00000073, post_decode_pkg::FU_SYSTEM, 16'h0000, 1'b0);
    add_row("fence",      32'h0FF0000F, post_decode_pkg::FU_SYSTEM, 16'h0000, 1'b0);
    add_row("branch_f3_2", 32'h00312463, post_decode_pkg::FU_NONE,  16'h0000, 1'b1);
    add_row("lwu",        32'h00016083, post_decode_pkg::FU_NONE,   16'h0000, 1'b1);
    add_row("store_f3_4", 32'h00314023, post_decode_pkg::FU_NONE,   16'h0000, 1'b1);
    add_row("system_f3_4", 32'h00004073, post_decode_pkg::FU_NONE,  16'h0000, 1'b1);
    add_row("flw",        32'h00012087, post_decode_pkg::FU_NONE,   16'h0000, 1'b1);
    add_row("fadd_s",     32'h003100D3, post_decode_pkg::FU_NONE,   16'h0000, 1'b1);
    add_row("unknown",    32'h0000007F, post_decode_pkg::FU_NONE,   16'h0000, 1'b1);
endtask

/* tb_post_decode.sv */
`timescale 1ns/1ps

module tb_post_decode;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 16;
    localparam int DRIVE_DELAY = 10;
    localparam int ROW_CYCLES  = 40;
    localparam logic [15:0] LFSR_SEED = 16'd40340;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    // Slot word is fu, ctrl, illegal, pc, rob_idx, rd_preg
    typedef struct packed {
        logic [1:0]       mask;
        logic [1:0][64:0] word;
    } bundle_t;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    logic                       in_ready;
    logic [1:0]                 in_slot_valid;
    logic [31:0]                in_inst_0;
    logic [31:0]                in_inst_1;
    logic [31:0]                in_pc_0;
    logic [31:0]                in_pc_1;
    logic [5:0]                 in_rob_idx_0;
    logic [5:0]                 in_rob_idx_1;
    logic [6:0]                 in_rd_preg_0;
    logic [6:0]                 in_rd_preg_1;
    logic                       out_valid;
    logic                       out_ready;
    logic [1:0]                 out_slot_valid;
    logic [2:0]                 out_fu_sel_0;
    logic [2:0]                 out_fu_sel_1;
    post_decode_pkg::uop_ctrl_u out_ctrl_0;
    post_decode_pkg::uop_ctrl_u out_ctrl_1;
    logic                       out_illegal_0;
    logic                       out_illegal_1;
    logic [31:0]                out_pc_0;
    logic [31:0]                out_pc_1;
    logic [5:0]                 out_rob_idx_0;
    logic [5:0]                 out_rob_idx_1;
    logic [6:0]                 out_rd_preg_0;
    logic [6:0]                 out_rd_preg_1;

    string       row_name [$];
    logic [31:0] row_inst [$];
    logic [2:0]  row_fu [$];
    logic [15:0] row_ctrl [$];
    logic        row_illegal [$];
    bundle_t     exp_q [$]; // Accepted but not yet out
    string       exp_name_q [$];
    bundle_t     offered;
    string       offered_name [2];
    logic [15:0] lfsr;
    logic        holding;
    logic        gap_a;
    logic        gap_b;
    int          n_rows;
    int          next_row;
    int          bundles;
    int          checks;
    int          mismatches;
    int          flow_errors;
    int          timeouts;

    post_decode DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic next_rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ LFSR_TAPS;
        return b;
    endfunction

    function automatic logic [31:0] pc_for(input int row);
        return 32'h0001_0000 + 32'(row) * 32'd4;
    endfunction

    function automatic logic [64:0] expect_slot(input logic valid, input int row);
        if (!valid)
            return {post_decode_pkg::FU_NONE, 62'h0}; // Cleared slot
        return {row_fu[row], row_ctrl[row], row_illegal[row], pc_for(row), 6'(row),
                7'(row + 40)};
    endfunction

    function automatic string describe(input logic [64:0] w);
        return $sformatf("fu=%0d ctrl=%h illegal=%b pc=%h rob=%0d preg=%0d",
                         w[64:62], w[61:46], w[45], w[44:13], w[12:7], w[6:0]);
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input logic [2:0] fu,
                           input logic [15:0] ctrl, input logic illegal);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_fu.push_back(fu);
        row_ctrl.push_back(ctrl);
        row_illegal.push_back(illegal);
    endtask

    `include "tb_vectors.svh"

    task automatic offer_bundle();
        logic [1:0] mask;
        int         row [2];
        int         k;
        case (bundles % 3)
            0: mask = 2'b11;
            1: mask = 2'b01;
            default: mask = 2'b10;
        endcase
        if (mask == 2'b11 && next_row + 1 >= n_rows)
            mask = 2'b01;
        // Empty slot still carries a real instruction
        row[0] = mask[0] ? next_row : (next_row + 1) % n_rows;
        row[1] = mask[0] ? (next_row + 1) % n_rows : next_row;
        next_row = next_row + ((mask == 2'b11) ? 2 : 1);
        bundles++;
        offered.mask = mask;
        for (k = 0; k < 2; k++) begin
            offered.word[k] = expect_slot(mask[k], row[k]);
            if (mask[k])
                offered_name[k] = row_name[row[k]];
            else
                offered_name[k] = "empty slot";
        end
        in_slot_valid = mask;
        in_inst_0     = row_inst[row[0]];
        in_inst_1     = row_inst[row[1]];
        in_pc_0       = pc_for(row[0]);
        in_pc_1       = pc_for(row[1]);
        in_rob_idx_0  = 6'(row[0]);
        in_rob_idx_1  = 6'(row[1]);
        in_rd_preg_0  = 7'(row[0] + 40);
        in_rd_preg_1  = 7'(row[1] + 40);
    endtask

    task automatic check_output();
        bundle_t     want;
        logic [64:0] got [2];
        string       name;
        int          k;
        want = exp_q.pop_front();
        got[0] = {out_fu_sel_0, out_ctrl_0, out_illegal_0, out_pc_0, out_rob_idx_0,
                  out_rd_preg_0};
        got[1] = {out_fu_sel_1, out_ctrl_1, out_illegal_1, out_pc_1, out_rob_idx_1,
                  out_rd_preg_1};
        checks++;
        assert (out_slot_valid === want.mask) else begin
            mismatches++;
            $display("Mismatch %s+%s slot_valid: expected %b, actual %b",
                     exp_name_q[0], exp_name_q[1], want.mask, out_slot_valid);
        end
        for (k = 0; k < 2; k++) begin
            name = exp_name_q.pop_front();
            checks++;
            assert (got[k] === want.word[k]) else begin
                mismatches++;
                $display("Mismatch %s slot %0d: expected %s, actual %s",
                         name, k, describe(want.word[k]), describe(got[k]));
            end
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, mismatches: %0d, flow errors: %0d, timeouts: %0d",
                 checks, mismatches, flow_errors, timeouts);
        if (checks > 0 && mismatches == 0 && flow_errors == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    initial begin
        lfsr = LFSR_SEED;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_slot_valid = '0;
        in_inst_0 = '0;
        in_inst_1 = '0;
        in_pc_0 = '0;
        in_pc_1 = '0;
        in_rob_idx_0 = '0;
        in_rob_idx_1 = '0;
        in_rd_preg_0 = '0;
        in_rd_preg_1 = '0;
        out_ready = 1'b0;
        holding = 1'b0;
        next_row = 0;
        bundles = 0;
        checks = 0;
        mismatches = 0;
        flow_errors = 0;
        timeouts = 0;
        load_table();
        n_rows = row_inst.size();
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        while (next_row < n_rows || in_valid || exp_q.size() > 0) begin
            checks += 2;
            assert (in_ready == (exp_q.size() < 2)) else begin
                flow_errors++;
                $display("in_ready is %b while %0d bundles are held", in_ready, exp_q.size());
            end
            assert (out_valid == (exp_q.size() > 0)) else begin
                flow_errors++;
                $display("out_valid is %b while %0d bundles are held", out_valid, exp_q.size());
            end
            out_ready = next_rand_bit();
            if (out_valid && out_ready && exp_q.size() > 0)
                check_output();
            if (!holding) begin
                gap_a = next_rand_bit();
                gap_b = next_rand_bit();
                in_valid = 1'b0;
                if (next_row < n_rows && !(gap_a && gap_b)) begin
                    offer_bundle();
                    in_valid = 1'b1;
                end
            end
            holding = in_valid && !in_ready; // Payload stays until taken
            if (in_valid && in_ready) begin
                exp_q.push_back(offered);
                exp_name_q.push_back(offered_name[0]);
                exp_name_q.push_back(offered_name[1]);
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        finish_run();
    end

    initial begin
        wait (n_rows > 0);
        #((RST_CYCLES + ROW_CYCLES * n_rows) * CLK_PERIOD);
        timeouts++;
        $display("Watchdog expired before every bundle came out of the DUT");
        finish_run();
    end

endmodule

/* project.f */
+incdir+.
post_decode_pkg.sv
uop_bus_if.sv
uop_decoder.sv
bundle_decode.sv
bundle_buffer.sv
post_decode.sv
tb_post_decode.sv

/* Bender.yml */
package:
  name: post_decode

sources:
  - post_decode_pkg.sv
  - uop_bus_if.sv
  - uop_decoder.sv
  - bundle_decode.sv
  - bundle_buffer.sv
  - post_decode.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_post_decode.sv
